/* run_sim.sh */
#!/bin/sh
# Build and run the convolution testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
RUN_LOG=sim.log

rm -rf obj_dir

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_conv_window -f tb.f --Mdir obj_dir -o tb_conv_window \
    > "$BUILD_LOG" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_conv_window > "$RUN_LOG" 2>&1
run_status=$?
cat "$RUN_LOG"

if grep -q "Checks failed" "$RUN_LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0

/* sim/conv_trace.txt */
# C <word>: 16-bit configuration word in hex, bit 15 set for bias and shift.
# P <p0..p6>: one pixel row in hex; E <r0..r6>: expected results of that row in hex.
# Coefficient words, tap index in bits 14:9, signed coefficient in bits 7:0.
C 3004
C 3202
C 2201
C 3aff
C 0c03
C 54fe
C 5001
C 1202
C 2a01
C 5cff
# Control word, bias -40 and shift 2.
C fb04
# Frame pixels, value 36*row + 5*col.
P 00 05 0a 0f 14 19 1e
P 24 29 2e 33 38 3d 42
P 48 4d 52 57 5c 61 66
P 6c 71 76 7b 80 85 8a
P 90 95 9a 9f a4 a9 ae
P b4 b9 be c3 c8 cd d2
P d8 dd e2 e7 ec f1 f6
# Expected results in raster order.
E 00 00 00 00 00 00 00
E 26 2f 26 00 00 00 00
E 65 6e 5e 20 29 05 0d
E b0 ce b9 76 68 3b 3a
E ff ff ff ff ff ff ec
E ff ff ff ff ff ff ff
E ff ff ff ff ff ff ff

/* sim/tb_conv_window.sv */
module tb_conv_window
    import conv_geom_pkg::*;
    import conv_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam string TRACE_FILE  = "sim/conv_trace.txt";
    localparam int    RST_CYCLES  = 4;
    localparam int    PIX_SLOT    = 4;   // One pixel plus up to three idle cycles.
    localparam int    MAC_LAT     = 3;
    localparam int    MARGIN      = 50;
    localparam int    TAIL_CYCLES = 8;

    logic             clk = 1'b0;
    logic             rst_n;
    logic [PIX_W-1:0] pixel_i;
    logic             pixel_valid_i;
    cfg_word_u        cfg_i;
    logic             cfg_wr_i;
    logic [RES_W-1:0] result_o;
    logic             result_valid_o;
    logic             frame_done_o;

    logic [15:0]      cfg_q [$];
    logic [PIX_W-1:0] pix_q [$];
    logic [RES_W-1:0] exp_q [$];

    int seed;
    int cycle_cnt;
    int cycle_limit;
    int res_cnt;
    bit pix_started;

    conv_window_top conv_window_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .pixel_i        (pixel_i),
        .pixel_valid_i  (pixel_valid_i),
        .cfg_i          (cfg_i),
        .cfg_wr_i       (cfg_wr_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .frame_done_o   (frame_done_o)
    );

    always #10 clk = ~clk;

    task automatic stop_with_fail();
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        stop_with_fail();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %s got 0x%0h expected 0x%0h", name, got, expected);
            stop_with_fail();
        end
    endtask

    task automatic read_trace();
        int          fd;
        int          n;
        string       line;
        logic [15:0] word;
        int          v [7];
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            abort_run("Could not open the trace file sim/conv_trace.txt.");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            case (line.getc(0))
                "C": begin
                    n = $sscanf(line, "C %h", word);
                    if (n != 1) begin
                        abort_run("A configuration line in the trace has no word.");
                    end
                    cfg_q.push_back(word);
                end
                "P", "E": begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h %h %h",
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
                    if (n != IMG_COLS) begin
                        abort_run("A row line in the trace does not hold seven values.");
                    end
                    for (int i = 0; i < IMG_COLS; i++) begin
                        if (line.getc(0) == "P") begin
                            pix_q.push_back(PIX_W'(v[i]));
                        end else begin
                            exp_q.push_back(RES_W'(v[i]));
                        end
                    end
                end
                default: abort_run("The trace holds a line of unknown kind.");
            endcase
        end
        $fclose(fd);
        if (pix_q.size() != FRAME_PIX || exp_q.size() != FRAME_PIX) begin
            abort_run("The trace does not hold one whole frame of pixels and results.");
        end
    endtask

    initial begin
        int gap;
        rst_n         = 1'b0;
        pixel_i       = '0;
        pixel_valid_i = 1'b0;
        cfg_i         = '0;
        cfg_wr_i      = 1'b0;
        seed          = 55;
        cycle_cnt     = 0;
        res_cnt       = 0;
        pix_started   = 1'b0;
        read_trace();
        cycle_limit = RST_CYCLES + cfg_q.size() + FRAME_PIX * PIX_SLOT + FLUSH_LEN +
                      MAC_LAT + MARGIN;

        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Kernel setup while the engine is idle.
        foreach (cfg_q[i]) begin
            @(posedge clk);
            cfg_i    <= cfg_q[i];
            cfg_wr_i <= 1'b1;
        end
        @(posedge clk);
        cfg_wr_i <= 1'b0;

        foreach (pix_q[i]) begin
            gap = $random(seed) & 3;
            repeat (gap) begin
                @(posedge clk);
                pixel_valid_i <= 1'b0;
            end
            @(posedge clk);
            pixel_i       <= pix_q[i];
            pixel_valid_i <= 1'b1;
            pix_started   = 1'b1;
        end
        @(posedge clk);
        pixel_valid_i <= 1'b0;  // Flush runs from here.
        pixel_i       <= '0;

        while (res_cnt < FRAME_PIX) begin
            @(posedge clk);
        end
        repeat (TAIL_CYCLES) @(posedge clk);  // Catch stray results.

        $display("All checks passed");
        $finish;
    end

    // Registered outputs are stable at the falling edge.
    always @(negedge clk) begin
        if (!pix_started) begin
            check_value("result_valid_o", result_valid_o, 1'b0);
        end
        if (result_valid_o) begin
            if (res_cnt >= exp_q.size()) begin
                abort_run("A result arrived after all expected results were seen.");
            end else begin
                check_value($sformatf("result_o[%0d]", res_cnt), result_o, exp_q[res_cnt]);
                check_value("frame_done_o", frame_done_o, res_cnt == FRAME_PIX - 1);
                res_cnt++;
            end
        end else begin
            check_value("frame_done_o", frame_done_o, 1'b0);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (res_cnt < FRAME_PIX && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, only %0d of %0d results arrived.",
                                cycle_cnt, res_cnt, FRAME_PIX));
        end
    end

endmodule

/* tb.f */
verilog/conv_geom_pkg.sv
verilog/conv_cfg_pkg.sv
verilog/pixel_line_buffer.sv
verilog/window_pad.sv
verilog/kernel_mac.sv
verilog/conv_window_top.sv
sim/tb_conv_window.sv

/* verilog/conv_cfg_pkg.sv */
package conv_cfg_pkg;

    localparam int COEF_W    = 8;
    localparam int ACC_W     = 22;  // 49 products plus bias.
    localparam int RES_W     = 8;
    localparam int TAP_IDX_W = 6;
    localparam int BIAS_W    = 10;
    localparam int SHIFT_W   = 4;

    localparam logic CFG_KIND_COEF = 1'b0;
    localparam logic CFG_KIND_CTRL = 1'b1;

    typedef struct packed {
        logic                     kind;   // CFG_KIND_COEF.
        logic [TAP_IDX_W-1:0]     tap;
        logic                     spare;
        logic signed [COEF_W-1:0] coef;
    } cfg_coef_t;

    typedef struct packed {
        logic                     kind;   // CFG_KIND_CTRL.
        logic signed [BIAS_W-1:0] bias;   // Added before the shift.
        logic [SHIFT_W-1:0]       shift;
        logic                     spare;
    } cfg_ctrl_t;

    // Bit 15 selects the view.
    typedef union packed {
        cfg_coef_t coef;
        cfg_ctrl_t ctrl;
    } cfg_word_u;

endpackage

/* verilog/conv_geom_pkg.sv */
package conv_geom_pkg;

    // Frame size in pixels.
    localparam int IMG_ROWS = 7;
    localparam int IMG_COLS = 7;

    // Square window around each centre pixel.
    localparam int KSIZE = 7;

    // Taps on each side of the centre.
    localparam int KPAD = 3;

    // Taps per window are numbered 7*dy + dx from the top-left corner.
    localparam int NTAPS = KSIZE * KSIZE;

    localparam int PIX_W = 8;

    localparam int FRAME_PIX = IMG_ROWS * IMG_COLS;

    // Zero shifts that push the last centre through the window.
    localparam int FLUSH_LEN = KPAD * IMG_COLS + KPAD;

endpackage

/* verilog/conv_window_top.sv */
module conv_window_top
    import conv_geom_pkg::*;
    import conv_cfg_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [PIX_W-1:0] pixel_i,
    input  logic             pixel_valid_i,
    input  cfg_word_u        cfg_i,
    input  logic             cfg_wr_i,
    output logic [RES_W-1:0] result_o,
    output logic             result_valid_o,
    output logic             frame_done_o
);

    logic [PIX_W-1:0]            row_tap0;
    logic [PIX_W-1:0]            row_tap1;
    logic [PIX_W-1:0]            row_tap2;
    logic [PIX_W-1:0]            row_tap3;
    logic [PIX_W-1:0]            row_tap4;
    logic [PIX_W-1:0]            row_tap5;
    logic [PIX_W-1:0]            row_tap6;
    logic                        shift;
    logic                        frame_start;
    logic [NTAPS-1:0][PIX_W-1:0] taps;
    logic                        window_valid;
    logic                        last_window;

    pixel_line_buffer pixel_line_buffer_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .pixel_i       (pixel_i),
        .pixel_valid_i (pixel_valid_i),
        .row_tap0_o    (row_tap0),
        .row_tap1_o    (row_tap1),
        .row_tap2_o    (row_tap2),
        .row_tap3_o    (row_tap3),
        .row_tap4_o    (row_tap4),
        .row_tap5_o    (row_tap5),
        .row_tap6_o    (row_tap6),
        .shift_o       (shift),
        .frame_start_o (frame_start)
    );

    window_pad window_pad_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .row_tap0_i     (row_tap0),
        .row_tap1_i     (row_tap1),
        .row_tap2_i     (row_tap2),
        .row_tap3_i     (row_tap3),
        .row_tap4_i     (row_tap4),
        .row_tap5_i     (row_tap5),
        .row_tap6_i     (row_tap6),
        .shift_i        (shift),
        .frame_start_i  (frame_start),
        .taps_o         (taps),
        .window_valid_o (window_valid),
        .last_window_o  (last_window)
    );

    kernel_mac kernel_mac_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_i          (cfg_i),
        .cfg_wr_i       (cfg_wr_i),
        .taps_i         (taps),
        .window_valid_i (window_valid),
        .last_window_i  (last_window),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .frame_done_o   (frame_done_o)
    );

endmodule

/* verilog/kernel_mac.sv */
module kernel_mac
    import conv_geom_pkg::*;
    import conv_cfg_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  cfg_word_u                   cfg_i,
    input  logic                        cfg_wr_i,
    input  logic [NTAPS-1:0][PIX_W-1:0] taps_i,
    input  logic                        window_valid_i,
    input  logic                        last_window_i,
    output logic [RES_W-1:0]            result_o,
    output logic                        result_valid_o,
    output logic                        frame_done_o
);

    logic signed [COEF_W-1:0]        coef_q [NTAPS];
    logic signed [BIAS_W-1:0]        bias_q;
    logic [SHIFT_W-1:0]              shift_q;
    logic signed [COEF_W+PIX_W-1:0]  prod_q [NTAPS];
    logic signed [ACC_W-1:0]         acc;
    logic signed [ACC_W-1:0]         sum_q;
    logic signed [ACC_W-1:0]         shifted;
    logic                            v1_q;
    logic                            v2_q;
    logic                            l1_q;
    logic                            l2_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < NTAPS; k++) begin
                coef_q[k] <= '0;
            end
            bias_q  <= '0;
            shift_q <= '0;
        end else if (cfg_wr_i) begin
            if (cfg_i.coef.kind == CFG_KIND_CTRL) begin
                bias_q  <= cfg_i.ctrl.bias;
                shift_q <= cfg_i.ctrl.shift;
            end else if (cfg_i.coef.tap < TAP_IDX_W'(NTAPS)) begin
                coef_q[cfg_i.coef.tap] <= cfg_i.coef.coef;
            end
        end
    end

    // Stage 1 takes the pixels as unsigned.
    always_ff @(posedge clk) begin
        for (int k = 0; k < NTAPS; k++) begin
            prod_q[k] <= coef_q[k] * $signed({1'b0, taps_i[k]});
        end
    end

    always_comb begin
        acc = {{(ACC_W - BIAS_W){bias_q[BIAS_W-1]}}, bias_q};
        for (int k = 0; k < NTAPS; k++) begin
            acc = acc + prod_q[k];
        end
    end

    // Stage 2.
    always_ff @(posedge clk) begin
        sum_q <= acc;
    end

    assign shifted = sum_q >>> shift_q;

    // Stage 3 clamps to 0..255.
    always_ff @(posedge clk) begin
        if (shifted[ACC_W-1]) begin
            result_o <= '0;
        end else if (|shifted[ACC_W-2:RES_W]) begin
            result_o <= '1;
        end else begin
            result_o <= shifted[RES_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1_q           <= 1'b0;
            v2_q           <= 1'b0;
            l1_q           <= 1'b0;
            l2_q           <= 1'b0;
            result_valid_o <= 1'b0;
            frame_done_o   <= 1'b0;
        end else begin
            v1_q           <= window_valid_i;
            l1_q           <= window_valid_i & last_window_i;
            v2_q           <= v1_q;
            l2_q           <= l1_q;
            result_valid_o <= v2_q;
            frame_done_o   <= v2_q & l2_q;
        end
    end

    // Coefficients and bias must hold steady for every window in flight.
    cfg_quiet_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        cfg_wr_i |-> !(window_valid_i || v1_q || v2_q || result_valid_o)
    );

endmodule

/* verilog/pixel_line_buffer.sv */
module pixel_line_buffer
    import conv_geom_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic [PIX_W-1:0] pixel_i,
    input  logic             pixel_valid_i,
    output logic [PIX_W-1:0] row_tap0_o,
    output logic [PIX_W-1:0] row_tap1_o,
    output logic [PIX_W-1:0] row_tap2_o,
    output logic [PIX_W-1:0] row_tap3_o,
    output logic [PIX_W-1:0] row_tap4_o,
    output logic [PIX_W-1:0] row_tap5_o,
    output logic [PIX_W-1:0] row_tap6_o,
    output logic             shift_o,
    output logic             frame_start_o
);

    logic [5:0]       pix_cnt;
    logic [4:0]       flush_cnt;
    logic             flushing;
    logic             shift;
    logic [PIX_W-1:0] sample;

    // Newest sample at index 0 and the sample six lines back at the far end.
    logic [PIX_W-1:0] line_q [(KSIZE-1)*IMG_COLS+1];

    assign shift  = pixel_valid_i | flushing;
    assign sample = flushing ? '0 : pixel_i;  // Zero rows below the frame.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix_cnt   <= '0;
            flush_cnt <= '0;
            flushing  <= 1'b0;
        end else if (flushing) begin
            if (flush_cnt == 5'(FLUSH_LEN - 1)) begin
                flush_cnt <= '0;
                flushing  <= 1'b0;
            end else begin
                flush_cnt <= flush_cnt + 5'd1;
            end
        end else if (pixel_valid_i) begin
            if (pix_cnt == 6'(FRAME_PIX - 1)) begin
                pix_cnt  <= '0;
                flushing <= 1'b1;   // Last pixel starts the flush.
            end else begin
                pix_cnt <= pix_cnt + 6'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_o       <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            shift_o       <= shift;
            frame_start_o <= pixel_valid_i & ~flushing & (pix_cnt == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (shift) begin
            line_q[0] <= sample;
            for (int i = 1; i < (KSIZE-1)*IMG_COLS+1; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    assign row_tap0_o = line_q[6*IMG_COLS];
    assign row_tap1_o = line_q[5*IMG_COLS];
    assign row_tap2_o = line_q[4*IMG_COLS];
    assign row_tap3_o = line_q[3*IMG_COLS];
    assign row_tap4_o = line_q[2*IMG_COLS];
    assign row_tap5_o = line_q[1*IMG_COLS];
    assign row_tap6_o = line_q[0];

    // A pixel during the flush would be lost.
    flush_no_pixel_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        flushing |-> !pixel_valid_i
    );

endmodule

/* verilog/window_pad.sv */
module window_pad
    import conv_geom_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [PIX_W-1:0]            row_tap0_i,
    input  logic [PIX_W-1:0]            row_tap1_i,
    input  logic [PIX_W-1:0]            row_tap2_i,
    input  logic [PIX_W-1:0]            row_tap3_i,
    input  logic [PIX_W-1:0]            row_tap4_i,
    input  logic [PIX_W-1:0]            row_tap5_i,
    input  logic [PIX_W-1:0]            row_tap6_i,
    input  logic                        shift_i,
    input  logic                        frame_start_i,
    output logic [NTAPS-1:0][PIX_W-1:0] taps_o,
    output logic                        window_valid_o,
    output logic                        last_window_o
);

    logic [PIX_W-1:0]            row_in [KSIZE];
    logic [PIX_W-1:0]            win_q  [KSIZE][KSIZE];
    logic [NTAPS-1:0][PIX_W-1:0] masked;
    logic [6:0]                  shift_cnt;
    logic [6:0]                  shift_idx;
    logic                        fire_q;
    logic [2:0]                  cen_row;
    logic [2:0]                  cen_col;

    assign row_in[0] = row_tap0_i;
    assign row_in[1] = row_tap1_i;
    assign row_in[2] = row_tap2_i;
    assign row_in[3] = row_tap3_i;
    assign row_in[4] = row_tap4_i;
    assign row_in[5] = row_tap5_i;
    assign row_in[6] = row_tap6_i;

    // Column KSIZE-1 holds the newest pixel of each row.
    always_ff @(posedge clk) begin
        if (shift_i) begin
            for (int r = 0; r < KSIZE; r++) begin
                for (int c = 0; c < KSIZE - 1; c++) begin
                    win_q[r][c] <= win_q[r][c+1];
                end
                win_q[r][KSIZE-1] <= row_in[r];
            end
        end
    end

    assign shift_idx = frame_start_i ? '0 : shift_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift_cnt <= '0;
            fire_q    <= 1'b0;
        end else begin
            if (shift_i) begin
                shift_cnt <= shift_idx + 7'd1;
            end
            fire_q <= shift_i & (shift_idx >= 7'(FLUSH_LEN));  // Window complete.
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cen_row <= '0;
            cen_col <= '0;
        end else if (frame_start_i) begin
            cen_row <= '0;
            cen_col <= '0;
        end else if (fire_q) begin
            if (cen_col == 3'(IMG_COLS - 1)) begin
                cen_col <= '0;
                cen_row <= (cen_row == 3'(IMG_ROWS - 1)) ? '0 : cen_row + 3'd1;
            end else begin
                cen_col <= cen_col + 3'd1;
            end
        end
    end

    // Tap position is centre plus offset biased by KPAD to stay unsigned.
    always_comb begin
        logic [3:0] row_pos;
        logic [3:0] col_pos;
        for (int r = 0; r < KSIZE; r++) begin
            for (int c = 0; c < KSIZE; c++) begin
                row_pos = {1'b0, cen_row} + 4'(r);
                col_pos = {1'b0, cen_col} + 4'(c);
                if (row_pos >= 4'(KPAD) && row_pos < 4'(KPAD + IMG_ROWS) &&
                    col_pos >= 4'(KPAD) && col_pos < 4'(KPAD + IMG_COLS)) begin
                    masked[r*KSIZE+c] = win_q[r][c];
                end else begin
                    masked[r*KSIZE+c] = '0;  // Outside or wrapped from the next line.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire_q) begin
            taps_o <= masked;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            window_valid_o <= 1'b0;
            last_window_o  <= 1'b0;
        end else begin
            window_valid_o <= fire_q;
            last_window_o  <= fire_q & (cen_row == 3'(IMG_ROWS - 1)) &
                              (cen_col == 3'(IMG_COLS - 1));
        end
    end

    // Centre index follows the shift count, so no window goes past centre 48.
    centre_in_frame_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        fire_q |-> (int'(cen_row) * IMG_COLS + int'(cen_col) ==
                    int'(shift_cnt) - FLUSH_LEN - 1)
    );

endmodule
